// ==== ex_unit.f ====
source/ex_ops_pkg.sv
source/ex_stage_pkg.sv
source/alu.sv
source/mdu.sv
source/execute.sv
source/ex_unit_top.sv
testbench/ex_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ex_unit_tb \
    -f ex_unit.f \
    -o ex_unit_sim

./obj_dir/ex_unit_sim 2>&1 | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  ex_ops_pkg::ex_op_t                    op,
    input  logic [ex_ops_pkg::data_width-1:0]     oprand1,
    input  logic [ex_ops_pkg::data_width-1:0]     oprand2,
    output logic [ex_ops_pkg::data_width-1:0]     result
);

    import ex_ops_pkg::*;

    logic                         sub_en;
    logic [data_width-1:0]        adder_b;
    logic [data_width-1:0]        add_res;
    logic                         cout;
    logic signed [data_width-1:0] op1_signed;
    logic [shamt_width-1:0]       shamt;
    logic                         lt_signed;
    logic                         lt_unsigned;

    assign sub_en     = op[0];
    assign op1_signed = oprand1;   // signed view for sra
    assign shamt      = oprand2[shamt_width-1:0];

    // one adder for add, sub and both compares
    assign adder_b         = sub_en ? ~oprand2 : oprand2;
    assign {cout, add_res} = {1'b0, oprand1} + {1'b0, adder_b} + {{data_width{1'b0}}, sub_en};

    // signs differ means op1 negative decides it, else the difference sign does
    assign lt_signed   = (oprand1[data_width-1] ^ oprand2[data_width-1]) ?
                         oprand1[data_width-1] : add_res[data_width-1];
    assign lt_unsigned = ~cout;   // borrow out

    always_comb
    begin
        case (op)
            alu_add, alu_sub:
                result = add_res;
            alu_and:
                result = oprand1 & oprand2;
            alu_or:
                result = oprand1 | oprand2;
            alu_xor:
                result = oprand1 ^ oprand2;
            alu_nor:
                result = ~(oprand1 | oprand2);
            alu_sll:
                result = oprand1 << shamt;
            alu_srl:
                result = oprand1 >> shamt;
            alu_sra:
                result = op1_signed >>> shamt;
            alu_slt:
                result = {{(data_width-1){1'b0}}, lt_signed};
            alu_sltu:
                result = {{(data_width-1){1'b0}}, lt_unsigned};
            default:
                result = '0;   // mdu codes and unknowns
        endcase
    end

endmodule

// ==== source/ex_ops_pkg.sv ====
package ex_ops_pkg;

    localparam int data_width     = 32;
    localparam int ex_op_width    = 6;
    localparam int lsu_op_width   = 3;
    localparam int reg_addr_width = 5;
    localparam int shamt_width    = 5;   // low bits of oprand2 used by shifts

    // bit 5 of the op code routes the operation to the MDU
    localparam int mdu_sel_bit    = 5;

    // divider runs one step per bit of the dividend
    localparam int div_steps      = data_width;
    localparam int div_cnt_width  = 5;

    // bit 0 set means the adder subtracts (sub, slt, sltu)
    typedef enum logic [ex_op_width-1:0] {
        alu_add  = 6'h00,
        alu_sub  = 6'h01,
        alu_and  = 6'h02,
        alu_slt  = 6'h03,
        alu_or   = 6'h04,
        alu_sltu = 6'h05,
        alu_xor  = 6'h06,
        alu_nor  = 6'h08,
        alu_sll  = 6'h0a,
        alu_srl  = 6'h0c,
        alu_sra  = 6'h0e,
        mdu_mul  = 6'h20,
        mdu_mulh = 6'h21,
        mdu_div  = 6'h22,
        mdu_mod  = 6'h23
    } ex_op_t;

    // memory stage decodes these, execute only carries them
    typedef enum logic [lsu_op_width-1:0] {
        lsu_none = 3'd0,
        lsu_lb   = 3'd1,
        lsu_lh   = 3'd2,
        lsu_lw   = 3'd3,
        lsu_sb   = 3'd4,
        lsu_sh   = 3'd5,
        lsu_sw   = 3'd6
    } lsu_op_t;

endpackage

// ==== source/ex_stage_pkg.sv ====
package ex_stage_pkg;

    import ex_ops_pkg::*;

    // decode to execute
    typedef struct packed {
        logic                      valid;
        ex_op_t                    ex_op;
        logic [data_width-1:0]     oprand1;
        logic [data_width-1:0]     oprand2;
        logic [data_width-1:0]     pc;
        logic [data_width-1:0]     inst;
        lsu_op_t                   lsu_op;
        logic [data_width-1:0]     lsu_data;   // store data
        logic                      rw_en;
        logic [reg_addr_width-1:0] rw_addr;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        logic                      valid;
        logic [data_width-1:0]     ex_result;
        logic [data_width-1:0]     pc;
        logic [data_width-1:0]     inst;
        lsu_op_t                   lsu_op;
        logic [data_width-1:0]     lsu_data;
        logic                      rw_en;
        logic [reg_addr_width-1:0] rw_addr;
    } ex_mem_t;

endpackage

// ==== source/ex_unit_top.sv ====
`timescale 1ns/1ps

module ex_unit_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  ex_stage_pkg::id_ex_t   id_info,
    output ex_stage_pkg::ex_mem_t  ex_info,
    output logic                   stall
);

    execute u_execute (
        .clk     (clk),
        .arst_n  (arst_n),
        .id_info (id_info),
        .ex_info (ex_info),
        .stall   (stall)
    );

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic                   clk,
    input  logic                   arst_n,
    input  ex_stage_pkg::id_ex_t   id_info,
    output ex_stage_pkg::ex_mem_t  ex_info,
    output logic                   stall
);

    import ex_ops_pkg::*;
    import ex_stage_pkg::*;

    logic [data_width-1:0] alu_res;
    logic [data_width-1:0] mdu_comb;
    logic [data_width-1:0] div_res;
    logic                  div_done;
    logic                  mdu_busy;
    logic                  is_mdu;
    logic                  is_div;
    logic                  accept;
    logic                  div_start;
    ex_mem_t               pass_w;
    ex_mem_t               pend_q;

    alu u_alu (
        .op      (id_info.ex_op),
        .oprand1 (id_info.oprand1),
        .oprand2 (id_info.oprand2),
        .result  (alu_res)
    );

    mdu u_mdu (
        .clk         (clk),
        .arst_n      (arst_n),
        .op          (id_info.ex_op),
        .oprand1     (id_info.oprand1),
        .oprand2     (id_info.oprand2),
        .start       (div_start),
        .comb_result (mdu_comb),
        .div_result  (div_res),
        .div_done    (div_done),
        .busy        (mdu_busy)
    );

    assign is_mdu    = id_info.ex_op[mdu_sel_bit];
    assign is_div    = is_mdu && (id_info.ex_op == mdu_div || id_info.ex_op == mdu_mod);
    assign stall     = mdu_busy;
    assign accept    = id_info.valid && !stall;
    assign div_start = accept && is_div;

    // single-cycle result plus the fields carried to memory stage
    always_comb
    begin
        pass_w.valid     = 1'b1;
        pass_w.ex_result = is_mdu ? mdu_comb : alu_res;
        pass_w.pc        = id_info.pc;
        pass_w.inst      = id_info.inst;
        pass_w.lsu_op    = id_info.lsu_op;
        pass_w.lsu_data  = id_info.lsu_data;
        pass_w.rw_en     = id_info.rw_en;
        pass_w.rw_addr   = id_info.rw_addr;
    end

    // fields of the divide in flight
    always_ff @(posedge clk)
    begin
        if (div_start)
            pend_q <= pass_w;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ex_info <= '0;
        else if (div_done)
        begin
            ex_info           <= pend_q;
            ex_info.ex_result <= div_res;
        end
        else if (accept && !is_div)
            ex_info <= pass_w;
        else
            ex_info.valid <= 1'b0;   // bubble, data left as is
    end

    a_no_valid_in_stall: assert property (
        @(posedge clk) disable iff (!arst_n) !(ex_info.valid && stall)
    );

endmodule

// ==== source/mdu.sv ====
`timescale 1ns/1ps

module mdu (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  ex_ops_pkg::ex_op_t                    op,
    input  logic [ex_ops_pkg::data_width-1:0]     oprand1,
    input  logic [ex_ops_pkg::data_width-1:0]     oprand2,
    input  logic                                  start,
    output logic [ex_ops_pkg::data_width-1:0]     comb_result,
    output logic [ex_ops_pkg::data_width-1:0]     div_result,
    output logic                                  div_done,
    output logic                                  busy
);

    import ex_ops_pkg::*;

    logic [2*data_width-1:0]  mul_res;
    logic [data_width-1:0]    rem_q;
    logic [data_width-1:0]    quo_q;
    logic [data_width-1:0]    divisor_q;
    ex_op_t                   op_q;
    logic [div_cnt_width-1:0] cnt_q;
    logic [data_width:0]      shifted;
    logic [data_width:0]      diff;
    logic                     fits;
    logic                     step_en;

    // unsigned multiply, done in the issue cycle
    assign mul_res = {{data_width{1'b0}}, oprand1} * {{data_width{1'b0}}, oprand2};

    always_comb
    begin
        case (op)
            mdu_mul:
                comb_result = mul_res[data_width-1:0];
            mdu_mulh:
                comb_result = mul_res[2*data_width-1:data_width];
            default:
                comb_result = '0;
        endcase
    end

    // restoring step: bring down next dividend bit, try the subtract
    assign shifted = {rem_q, quo_q[data_width-1]};
    assign diff    = shifted - {1'b0, divisor_q};
    assign fits    = ~diff[data_width];   // no borrow, also always true for divisor 0
    assign step_en = busy & ~div_done;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy     <= 1'b0;
            div_done <= 1'b0;
            cnt_q    <= '0;
        end
        else if (start)
        begin
            busy  <= 1'b1;
            cnt_q <= '0;
        end
        else if (div_done)
        begin
            busy     <= 1'b0;   // held through the done cycle
            div_done <= 1'b0;
        end
        else if (busy)
        begin
            cnt_q    <= cnt_q + 1'b1;
            div_done <= (cnt_q == div_cnt_width'(div_steps - 1));
        end
    end

    // datapath regs
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rem_q     <= '0;
            quo_q     <= oprand1;   // dividend shifts out as quotient shifts in
            divisor_q <= oprand2;
            op_q      <= op;
        end
        else if (step_en)
        begin
            rem_q <= fits ? diff[data_width-1:0] : shifted[data_width-1:0];
            quo_q <= {quo_q[data_width-2:0], fits};
        end
    end

    assign div_result = (op_q == mdu_mod) ? rem_q : quo_q;

    // execute must hold off new divides until this one drains
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!arst_n) !(start && busy)
    );

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) div_done |=> !div_done
    );

endmodule

// ==== testbench/ex_unit_tb.sv ====
`timescale 1ns/1ps

module ex_unit_tb;

    import ex_ops_pkg::*;
    import ex_stage_pkg::*;

    localparam logic [31:0] seed         = 32'hbbde_faec;
    localparam int          n_edge       = 8;
    localparam int          n_rand_alu   = 6;
    localparam int          n_rand_mul   = 8;
    localparam int          n_div_per_op = 11;
    localparam int          b2b_len      = 32;
    localparam int          div_limit    = 40;   // cycles allowed per divide
    localparam int          drain_limit  = 50;

    localparam int alu_cycles      = 11 * (n_edge + n_rand_alu) * 2;
    localparam int mul_cycles      = 2 * (4 + n_rand_mul) * 2;
    localparam int div_cycles      = (2 * n_div_per_op + 1) * div_limit;
    localparam int watchdog_cycles = 16 + alu_cycles + b2b_len + 4 + mul_cycles
                                     + div_cycles + 200;

    localparam ex_op_t alu_ops [0:10] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_nor, alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu};
    localparam ex_op_t stream_ops [0:12] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_nor, alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu, mdu_mul, mdu_mulh};

    // zero, all ones, sign bit, shifts by 0 and 31, equal pairs
    localparam logic [31:0] edge_a [0:7] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
        32'hffff_ffff, 32'h8000_0000, 32'h8000_0001, 32'h7fff_ffff, 32'h8000_0000};
    localparam logic [31:0] edge_b [0:7] = '{32'h0000_0000, 32'hffff_ffff, 32'hffff_ffff,
        32'h8000_0000, 32'h0000_001f, 32'h0000_0000, 32'h8000_0000, 32'h8000_0000};

    logic        clk;
    logic        arst_n;
    id_ex_t      id_info;
    ex_mem_t     ex_info;
    logic        stall;

    logic [31:0] rng_state;
    string       cur_test;
    ex_mem_t     exp_q[$];
    int          out_count;

    ex_unit_top u_ex_unit_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .id_info (id_info),
        .ex_info (ex_info),
        .stall   (stall)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    task automatic report_fail();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            report_fail();
        end
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // expected result straight from the operation definitions
    function automatic logic [31:0] model_result(ex_op_t op, logic [31:0] a, logic [31:0] b);
        logic [63:0] prod;
        logic [31:0] res;
        prod = {32'd0, a} * {32'd0, b};   // unsigned product
        case (op)
            alu_add:  res = a + b;
            alu_sub:  res = a - b;
            alu_and:  res = a & b;
            alu_or:   res = a | b;
            alu_xor:  res = a ^ b;
            alu_nor:  res = ~(a | b);
            alu_sll:  res = a << b[4:0];
            alu_srl:  res = a >> b[4:0];
            alu_sra:  res = $signed(a) >>> b[4:0];
            alu_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
            mdu_mul:  res = prod[31:0];
            mdu_mulh: res = prod[63:32];
            mdu_div:  res = (b == 32'd0) ? 32'hffff_ffff : a / b;
            mdu_mod:  res = (b == 32'd0) ? a : a % b;
            default:  res = 32'd0;
        endcase
        return res;
    endfunction

    function automatic id_ex_t make_item(ex_op_t op, logic [31:0] a, logic [31:0] b);
        id_ex_t      item;
        logic [31:0] r;
        r = next_rand();
        item.valid    = 1'b1;
        item.ex_op    = op;
        item.oprand1  = a;
        item.oprand2  = b;
        item.pc       = {r[31:2], 2'b00};
        item.inst     = next_rand();
        item.lsu_op   = (r[1:0] == 2'd3) ? lsu_sw : lsu_op_t'({1'b0, r[1:0]});
        item.lsu_data = next_rand();
        item.rw_en    = r[0];
        item.rw_addr  = r[6:2];
        return item;
    endfunction

    function automatic ex_mem_t expected_output(id_ex_t item);
        ex_mem_t res;
        res.valid     = 1'b1;
        res.ex_result = model_result(item.ex_op, item.oprand1, item.oprand2);
        res.pc        = item.pc;
        res.inst      = item.inst;
        res.lsu_op    = item.lsu_op;
        res.lsu_data  = item.lsu_data;
        res.rw_en     = item.rw_en;
        res.rw_addr   = item.rw_addr;
        return res;
    endfunction

    task automatic compare_output(input string name, input ex_mem_t exp, input ex_mem_t act);
        check_value({name, " result"}, exp.ex_result, act.ex_result);
        check_value({name, " pc"}, exp.pc, act.pc);
        check_value({name, " inst"}, exp.inst, act.inst);
        check_value({name, " lsu_data"}, exp.lsu_data, act.lsu_data);
        check_value({name, " lsu/rw fields"}, {23'd0, exp.lsu_op, exp.rw_en, exp.rw_addr},
                    {23'd0, act.lsu_op, act.rw_en, act.rw_addr});
    endtask

    // outputs are checked in order against the queue, at the falling edge
    initial
    begin : output_monitor
        ex_mem_t exp_item;
        forever
        begin
            @(negedge clk);
            if (arst_n === 1'b1 && ex_info.valid)
            begin
                if (stall)
                begin
                    $display("output valid seen while stall is high in %s", cur_test);
                    report_fail();
                end
                else if (exp_q.size() == 0)
                begin
                    $display("output valid seen with no operation outstanding in %s", cur_test);
                    report_fail();
                end
                else
                begin
                    exp_item = exp_q.pop_front();
                    compare_output(cur_test, exp_item, ex_info);
                    out_count++;
                end
            end
        end
    end

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic issue(input id_ex_t item, output int waits);
        id_info = item;
        exp_q.push_back(expected_output(item));
        waits = 0;
        @(negedge clk);
        while (stall)
        begin
            waits++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_single(input id_ex_t item);
        int waits;
        issue(item, waits);
        check_value({cur_test, " stall cycles"}, 32'd0, waits);
        id_info.valid = 1'b0;
        @(negedge clk);
        check_value({cur_test, " valid"}, 32'd1, {31'd0, ex_info.valid});
        @(posedge clk);
        #1;
    endtask

    task automatic run_divide(input id_ex_t item);
        int waits;
        int cycles;
        issue(item, waits);
        check_value({cur_test, " stall cycles"}, 32'd0, waits);
        id_info = '0;
        cycles = 0;
        @(negedge clk);
        check_value({cur_test, " stall rise"}, 32'd1, {31'd0, stall});
        while (!ex_info.valid && cycles < div_limit)
        begin
            check_value({cur_test, " stall"}, 32'd1, {31'd0, stall});
            cycles++;
            @(negedge clk);
        end
        if (!ex_info.valid)
        begin
            $display("divide result did not appear within %0d cycles", div_limit);
            report_fail();
        end
        else
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < drain_limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d expected outputs never appeared in %s", exp_q.size(), cur_test);
            report_fail();
        end
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        arst_n = 1'b0;
        id_info = '0;
        repeat (5)
        begin
            @(negedge clk);
            check_value({cur_test, " valid"}, 32'd0, {31'd0, ex_info.valid});
            check_value({cur_test, " stall"}, 32'd0, {31'd0, stall});
            check_value({cur_test, " result"}, 32'd0, ex_info.ex_result);
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            check_value({cur_test, " valid after"}, 32'd0, {31'd0, ex_info.valid});
            check_value({cur_test, " stall after"}, 32'd0, {31'd0, stall});
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_alu_ops();
        cur_test = "test_alu_ops";
        for (int i = 0; i < 11; i++)
        begin
            for (int k = 0; k < n_edge; k++)
                run_single(make_item(alu_ops[i], edge_a[k], edge_b[k]));
            for (int k = 0; k < n_rand_alu; k++)
                run_single(make_item(alu_ops[i], next_rand(), next_rand()));
        end
    endtask

    task automatic test_back_to_back();
        int start_count;
        int waits;
        int idx;
        cur_test = "test_back_to_back";
        start_count = out_count;
        for (int i = 0; i < b2b_len; i++)
        begin
            idx = int'(next_rand() % 32'd13);
            issue(make_item(stream_ops[idx], next_rand(), next_rand()), waits);
            check_value({cur_test, " stall cycles"}, 32'd0, waits);
            check_value({cur_test, " outputs so far"}, i, out_count - start_count);
        end
        id_info = '0;
        @(posedge clk);
        #1;
        check_value({cur_test, " outputs"}, b2b_len, out_count - start_count);
    endtask

    task automatic test_multiply();
        ex_op_t op;
        cur_test = "test_multiply";
        for (int j = 0; j < 2; j++)
        begin
            op = (j == 0) ? mdu_mul : mdu_mulh;
            run_single(make_item(op, 32'hffff_ffff, 32'hffff_ffff));
            run_single(make_item(op, 32'hffff_ffff, 32'h0000_0001));
            run_single(make_item(op, 32'h8000_0000, 32'h0000_0002));
            run_single(make_item(op, 32'h0000_0000, 32'hffff_ffff));
            for (int k = 0; k < n_rand_mul; k++)
                run_single(make_item(op, next_rand(), next_rand()));
        end
    endtask

    task automatic test_divide();
        ex_op_t      op;
        logic [31:0] a;
        cur_test = "test_divide";
        for (int j = 0; j < 2; j++)
        begin
            op = (j == 0) ? mdu_div : mdu_mod;
            for (int k = 0; k < 6; k++)
            begin
                a = next_rand();
                run_divide(make_item(op, a, next_rand() >> (k * 5)));   // varied divisor size
            end
            run_divide(make_item(op, next_rand(), 32'd1));
            run_divide(make_item(op, next_rand(), 32'd0));
            run_divide(make_item(op, 32'd0, 32'd0));
            run_divide(make_item(op, 32'd5, 32'd7));
            run_divide(make_item(op, 32'hffff_ffff, 32'hffff_ffff));
        end
    endtask

    task automatic test_mixed_stall();
        int     waits;
        id_ex_t div_item;
        id_ex_t alu_item;
        cur_test = "test_mixed_stall";
        div_item = make_item(mdu_div, next_rand(), (next_rand() >> 20) | 32'd1);
        alu_item = make_item(alu_xor, next_rand(), next_rand());
        issue(div_item, waits);
        issue(alu_item, waits);   // held on id_info while stall is high
        if (waits == 0)
        begin
            $display("ALU operation was accepted during the divide stall");
            report_fail();
        end
        else
        begin
            id_info = '0;
            drain();
        end
    endtask

    initial
    begin
        rng_state    = seed;
        arst_n       = 1'b0;
        id_info      = '0;
        out_count    = 0;
        test_reset();
        test_alu_ops();
        test_back_to_back();
        test_multiply();
        test_divide();
        test_mixed_stall();
        drain();
        $display("** PASS **");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        report_fail();
    end

endmodule
